// ==== logic/rv_pkg.sv ====
package rv_pkg;

  // data and address width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // base opcodes of rv32i
  typedef enum logic [6:0] {
    op_load     = 7'b000_0011,
    op_misc_mem = 7'b000_1111,
    op_reg_imm  = 7'b001_0011,
    op_auipc    = 7'b001_0111,
    op_store    = 7'b010_0011,
    op_reg_reg  = 7'b011_0011,
    op_lui      = 7'b011_0111,
    op_branch   = 7'b110_0011,
    op_jalr     = 7'b110_0111,
    op_jal      = 7'b110_1111,
    op_system   = 7'b111_0011
  } opcode_t;

  // funct3 of register-register and register-immediate ops
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 of conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  // low two bits of a load/store funct3, bit 2 selects zero extension
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_pc_plus4
  } wb_sel_t;

  // one instruction word seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      opcode_t    opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm_11_0;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      opcode_t     opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      opcode_t    opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      opcode_t    opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      reg_idx_t    rd;
      opcode_t     opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      reg_idx_t   rd;
      opcode_t    opcode;
    } j_fmt;
  } insn_t;

endpackage

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::insn_t   i_insn,
  output rv_pkg::word_t   o_imm,
  output rv_pkg::alu_op_t o_alu_op,
  output logic            o_src_a_pc,
  output logic            o_src_b_imm,
  output logic            o_reg_we,
  output rv_pkg::wb_sel_t o_wb_sel,
  output logic            o_is_load,
  output logic            o_is_store,
  output logic            o_is_branch,
  output logic            o_is_jal,
  output logic            o_is_jalr,
  output logic            o_is_ecall
);

  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;
  logic          ecall_fields_zero;

  // immediates, each sign-extended from its own format
  assign imm_i = {{20{i_insn.i_fmt.imm_11_0[11]}}, i_insn.i_fmt.imm_11_0};
  assign imm_s = {{20{i_insn.s_fmt.imm_11_5[6]}}, i_insn.s_fmt.imm_11_5, i_insn.s_fmt.imm_4_0};
  assign imm_b = {{19{i_insn.b_fmt.imm_12}}, i_insn.b_fmt.imm_12, i_insn.b_fmt.imm_11,
                  i_insn.b_fmt.imm_10_5, i_insn.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {i_insn.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{11{i_insn.j_fmt.imm_20}}, i_insn.j_fmt.imm_20, i_insn.j_fmt.imm_19_12,
                  i_insn.j_fmt.imm_11, i_insn.j_fmt.imm_10_1, 1'b0};

  // ecall has every field other than the opcode at zero
  assign ecall_fields_zero = (i_insn.i_fmt.imm_11_0 == '0) && (i_insn.i_fmt.rs1 == '0) &&
                             (i_insn.i_fmt.funct3 == '0) && (i_insn.i_fmt.rd == '0);

  // sub only exists in register-register form, sra in both
  function automatic rv_pkg::alu_op_t arith_op(input logic [2:0] funct3,
                                               input logic alt, input logic is_reg);
    rv_pkg::alu_op_t op;
    case (funct3)
      rv_pkg::f3_add_sub: op = (alt && is_reg) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll:     op = rv_pkg::alu_sll;
      rv_pkg::f3_slt:     op = rv_pkg::alu_slt;
      rv_pkg::f3_sltu:    op = rv_pkg::alu_sltu;
      rv_pkg::f3_xor:     op = rv_pkg::alu_xor;
      rv_pkg::f3_srl_sra: op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:      op = rv_pkg::alu_or;
      default:            op = rv_pkg::alu_and;
    endcase
    return op;
  endfunction

  always_comb begin
    o_imm       = '0;
    o_alu_op    = rv_pkg::alu_add;
    o_src_a_pc  = 1'b0;
    o_src_b_imm = 1'b0;
    o_reg_we    = 1'b0;
    o_wb_sel    = rv_pkg::wb_alu;
    o_is_load   = 1'b0;
    o_is_store  = 1'b0;
    o_is_branch = 1'b0;
    o_is_jal    = 1'b0;
    o_is_jalr   = 1'b0;
    o_is_ecall  = 1'b0;
    case (i_insn.r_fmt.opcode)
      rv_pkg::op_reg_reg: begin
        o_alu_op = arith_op(i_insn.r_fmt.funct3, i_insn.r_fmt.funct7[5], 1'b1);
        o_reg_we = 1'b1;
      end
      rv_pkg::op_reg_imm: begin
        o_imm       = imm_i;
        o_src_b_imm = 1'b1;
        o_alu_op    = arith_op(i_insn.r_fmt.funct3, i_insn.r_fmt.funct7[5], 1'b0);
        o_reg_we    = 1'b1;
      end
      rv_pkg::op_lui: begin
        o_imm       = imm_u;
        o_src_b_imm = 1'b1;
        o_alu_op    = rv_pkg::alu_pass_b;
        o_reg_we    = 1'b1;
      end
      rv_pkg::op_auipc: begin
        o_imm       = imm_u;
        o_src_a_pc  = 1'b1;
        o_src_b_imm = 1'b1;
        o_reg_we    = 1'b1;
      end
      rv_pkg::op_load: begin
        o_imm       = imm_i;
        o_src_b_imm = 1'b1;
        o_reg_we    = 1'b1;
        o_wb_sel    = rv_pkg::wb_load;
        o_is_load   = 1'b1;
      end
      rv_pkg::op_store: begin
        o_imm       = imm_s;
        o_src_b_imm = 1'b1;
        o_is_store  = 1'b1;
      end
      rv_pkg::op_branch: begin
        // alu compares rs1 against rs2, target comes from the core adder
        o_imm       = imm_b;
        o_is_branch = 1'b1;
      end
      rv_pkg::op_jal: begin
        o_imm    = imm_j;
        o_reg_we = 1'b1;
        o_wb_sel = rv_pkg::wb_pc_plus4;
        o_is_jal = 1'b1;
      end
      rv_pkg::op_jalr: begin
        o_imm       = imm_i;
        o_src_b_imm = 1'b1;
        o_reg_we    = 1'b1;
        o_wb_sel    = rv_pkg::wb_pc_plus4;
        o_is_jalr   = 1'b1;
      end
      rv_pkg::op_system: begin
        o_is_ecall = ecall_fields_zero;
      end
      // fence and unknown opcodes fall through as no-ops
      default: begin
        o_reg_we = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile #(
  parameter int num_regs = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t i_rs1,
  input  rv_pkg::reg_idx_t i_rs2,
  input  rv_pkg::reg_idx_t i_rd,
  input  logic             i_we,
  input  rv_pkg::word_t    i_rd_data,
  output rv_pkg::word_t    o_rs1_data,
  output rv_pkg::word_t    o_rs2_data
);

  rv_pkg::word_t regs [num_regs];

  // x0 and indices past the register count read as zero
  assign o_rs1_data = (i_rs1 != '0 && int'(i_rs1) < num_regs) ? regs[i_rs1] : '0;
  assign o_rs2_data = (i_rs2 != '0 && int'(i_rs2) < num_regs) ? regs[i_rs2] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0 && int'(i_rd) < num_regs) begin
      regs[i_rd] <= i_rd_data;
    end
  end

endmodule

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::word_t   i_a,
  input  rv_pkg::word_t   i_b,
  input  rv_pkg::alu_op_t i_op,
  input  logic [2:0]      i_branch_funct3,
  output rv_pkg::word_t   o_result,
  output logic            o_branch_taken
);

  logic       eq;
  logic       lt;
  logic       ltu;
  logic [4:0] shamt;

  // comparisons shared by set-less-than and the branches
  assign eq    = (i_a == i_b);
  assign lt    = ($signed(i_a) < $signed(i_b));
  assign ltu   = (i_a < i_b);
  assign shamt = i_b[4:0];

  always_comb begin
    case (i_op)
      rv_pkg::alu_add:    o_result = i_a + i_b;
      rv_pkg::alu_sub:    o_result = i_a - i_b;
      rv_pkg::alu_sll:    o_result = i_a << shamt;
      rv_pkg::alu_slt:    o_result = {31'b0, lt};
      rv_pkg::alu_sltu:   o_result = {31'b0, ltu};
      rv_pkg::alu_xor:    o_result = i_a ^ i_b;
      rv_pkg::alu_srl:    o_result = i_a >> shamt;
      rv_pkg::alu_sra:    o_result = $signed(i_a) >>> shamt;
      rv_pkg::alu_or:     o_result = i_a | i_b;
      rv_pkg::alu_and:    o_result = i_a & i_b;
      rv_pkg::alu_pass_b: o_result = i_b;
      default:            o_result = '0;
    endcase
  end

  // branch condition, only meaningful while a branch is decoded
  always_comb begin
    case (i_branch_funct3)
      rv_pkg::f3_beq:  o_branch_taken = eq;
      rv_pkg::f3_bne:  o_branch_taken = !eq;
      rv_pkg::f3_blt:  o_branch_taken = lt;
      rv_pkg::f3_bge:  o_branch_taken = !lt;
      rv_pkg::f3_bltu: o_branch_taken = ltu;
      rv_pkg::f3_bgeu: o_branch_taken = !ltu;
      default:         o_branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== logic/rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu (
  input  rv_pkg::word_t i_addr,
  input  logic [2:0]    i_funct3,
  input  logic          i_is_load,
  input  logic          i_is_store,
  input  rv_pkg::word_t i_store_src,
  input  rv_pkg::word_t i_load_data,
  output rv_pkg::word_t o_dmem_addr,
  output rv_pkg::word_t o_store_data,
  output logic [3:0]    o_store_we,
  output rv_pkg::word_t o_load_value
);

  rv_pkg::mem_size_t size;
  logic [1:0]        offset;
  logic              zero_ext;
  logic [7:0]        load_byte;
  logic [15:0]       load_half;
  rv_pkg::word_t     load_ext;
  logic [3:0]        lane_we;

  assign size        = rv_pkg::mem_size_t'(i_funct3[1:0]);
  assign zero_ext    = i_funct3[2];
  assign offset      = i_addr[1:0];
  assign o_dmem_addr = {i_addr[31:2], 2'b00};

  // store data is replicated so every lane carries the right bytes
  always_comb begin
    case (size)
      rv_pkg::size_byte: begin
        o_store_data = {4{i_store_src[7:0]}};
        lane_we      = 4'b0001 << offset;
      end
      rv_pkg::size_half: begin
        o_store_data = {2{i_store_src[15:0]}};
        lane_we      = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        o_store_data = i_store_src;
        lane_we      = 4'b1111;
      end
    endcase
  end

  assign o_store_we = i_is_store ? lane_we : 4'b0000;

  // pick the addressed byte or half out of the word
  assign load_byte = i_load_data[8*offset +: 8];
  assign load_half = offset[1] ? i_load_data[31:16] : i_load_data[15:0];

  always_comb begin
    case (size)
      rv_pkg::size_byte: load_ext = {{24{load_byte[7] & ~zero_ext}}, load_byte};
      rv_pkg::size_half: load_ext = {{16{load_half[15] & ~zero_ext}}, load_half};
      default:           load_ext = i_load_data;
    endcase
  end

  assign o_load_value = i_is_load ? load_ext : '0;

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
  parameter int            num_regs = 32,
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t o_pc,
  input  rv_pkg::word_t i_insn,
  output rv_pkg::word_t o_dmem_addr,
  input  rv_pkg::word_t i_load_data,
  output rv_pkg::word_t o_store_data,
  output logic [3:0]    o_store_we,
  output logic          o_halt
);

  rv_pkg::insn_t   insn;
  rv_pkg::word_t   pc_q;
  rv_pkg::word_t   pc_next;
  rv_pkg::word_t   pc_plus4;
  rv_pkg::word_t   pc_target;
  rv_pkg::word_t   imm;
  rv_pkg::alu_op_t alu_op;
  rv_pkg::wb_sel_t wb_sel;
  logic            src_a_pc;
  logic            src_b_imm;
  logic            reg_we;
  logic            is_load;
  logic            is_store;
  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;
  logic            is_ecall;
  logic            branch_taken;
  rv_pkg::word_t   rs1_data;
  rv_pkg::word_t   rs2_data;
  rv_pkg::word_t   alu_a;
  rv_pkg::word_t   alu_b;
  rv_pkg::word_t   alu_result;
  rv_pkg::word_t   load_value;
  rv_pkg::word_t   rd_data;

  assign insn = i_insn;

  rv_decoder decoder_i (
    .i_insn      (insn),
    .o_imm       (imm),
    .o_alu_op    (alu_op),
    .o_src_a_pc  (src_a_pc),
    .o_src_b_imm (src_b_imm),
    .o_reg_we    (reg_we),
    .o_wb_sel    (wb_sel),
    .o_is_load   (is_load),
    .o_is_store  (is_store),
    .o_is_branch (is_branch),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr),
    .o_is_ecall  (is_ecall)
  );

  rv_regfile #(
    .num_regs (num_regs)
  ) regfile_i (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (insn.r_fmt.rs1),
    .i_rs2      (insn.r_fmt.rs2),
    .i_rd       (insn.r_fmt.rd),
    .i_we       (reg_we),
    .i_rd_data  (rd_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  assign alu_a = src_a_pc ? pc_q : rs1_data;
  assign alu_b = src_b_imm ? imm : rs2_data;

  rv_alu alu_i (
    .i_a             (alu_a),
    .i_b             (alu_b),
    .i_op            (alu_op),
    .i_branch_funct3 (insn.r_fmt.funct3),
    .o_result        (alu_result),
    .o_branch_taken  (branch_taken)
  );

  // the alu sum is the effective address
  rv_lsu lsu_i (
    .i_addr       (alu_result),
    .i_funct3     (insn.r_fmt.funct3),
    .i_is_load    (is_load),
    .i_is_store   (is_store),
    .i_store_src  (rs2_data),
    .i_load_data  (i_load_data),
    .o_dmem_addr  (o_dmem_addr),
    .o_store_data (o_store_data),
    .o_store_we   (o_store_we),
    .o_load_value (load_value)
  );

  assign pc_plus4  = pc_q + 32'd4;
  assign pc_target = pc_q + imm;

  // ecall parks the pc so halt stays asserted
  always_comb begin
    if (is_ecall) begin
      pc_next = pc_q;
    end else if (is_jalr) begin
      pc_next = {alu_result[31:1], 1'b0};
    end else if (is_jal || (is_branch && branch_taken)) begin
      pc_next = pc_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= reset_pc;
    end else begin
      pc_q <= pc_next;
    end
  end

  // writeback source
  always_comb begin
    case (wb_sel)
      rv_pkg::wb_load:     rd_data = load_value;
      rv_pkg::wb_pc_plus4: rd_data = pc_plus4;
      default:             rd_data = alu_result;
    endcase
  end

  assign o_pc   = pc_q;
  assign o_halt = is_ecall;

endmodule

// ==== verif/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

  localparam int mem_words   = 1024;
  localparam int tdata_words = 1024;
  localparam int clk_period  = 100;

  logic        clk;
  logic        rst;
  logic [31:0] pc;
  logic [31:0] insn;
  logic [31:0] dmem_addr;
  logic [31:0] load_data;
  logic [31:0] store_data;
  logic [3:0]  store_we;
  logic        halt;

  logic [31:0] mem [mem_words];
  logic [31:0] tdata [tdata_words];
  logic [31:0] lfsr_state;

  int prog_len;
  int num_stores;
  int data_base;
  int data_count;
  int record_base;
  int store_idx;
  bit loaded;

  rv_core #(
    .num_regs (32),
    .reset_pc (32'h0000_0000)
  ) dut_i (
    .clk          (clk),
    .rst          (rst),
    .o_pc         (pc),
    .i_insn       (insn),
    .o_dmem_addr  (dmem_addr),
    .i_load_data  (load_data),
    .o_store_data (store_data),
    .o_store_we   (store_we),
    .o_halt       (halt)
  );

  // memory answers fetch and load in the same cycle
  assign insn      = mem[pc[11:2]];
  assign load_data = mem[dmem_addr[11:2]];

  initial begin
    clk = 1'b0;
    forever begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] we);
    return {{8{we[3]}}, {8{we[2]}}, {8{we[1]}}, {8{we[0]}}};
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s expected %08h actual %08h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // one random word takes 32 lfsr steps, one per bit
  task automatic fill_memory();
    logic [31:0] w;
    for (int i = 0; i < mem_words; i++) begin
      w = '0;
      for (int b = 0; b < 32; b++) begin
        lfsr_state = lfsr_next(lfsr_state);
        w = {w[30:0], lfsr_state[0]};
      end
      mem[i] = w;
    end
  endtask

  task automatic load_testdata();
    $readmemh("verif/rv_testdata.hex", tdata);
    prog_len    = int'(tdata[0]);
    num_stores  = int'(tdata[1]);
    data_base   = int'(tdata[2]);
    data_count  = int'(tdata[3]);
    record_base = 4 + prog_len + data_count;
    for (int i = 0; i < prog_len; i++) begin
      mem[i] = tdata[4 + i];
    end
    for (int i = 0; i < data_count; i++) begin
      mem[data_base + i] = tdata[4 + prog_len + i];
    end
  endtask

  // stores are checked mid-cycle where the outputs are settled
  always @(negedge clk) begin
    logic [31:0] mask;
    int          rec;
    if (!rst && loaded && store_we !== 4'b0000) begin
      if (store_idx >= num_stores) begin
        stop_with_failure("more stores were seen than the test data expects");
      end
      rec  = record_base + 3 * store_idx;
      mask = lane_mask(tdata[rec + 1][3:0]);
      check_value($sformatf("store %0d address", store_idx), tdata[rec], dmem_addr);
      check_value($sformatf("store %0d byte enable", store_idx), tdata[rec + 1],
                  {28'b0, store_we});
      check_value($sformatf("store %0d data", store_idx), tdata[rec + 2],
                  store_data & mask);
      mem[dmem_addr[11:2]] = (mem[dmem_addr[11:2]] & ~mask) | (store_data & mask);
      store_idx++;
    end
  end

  // allow four cycles per program word plus reset
  initial begin
    wait (loaded);
    #((prog_len * 4 + 20) * clk_period);
    stop_with_failure("timeout, halt never arrived");
  end

  initial begin
    logic [31:0] halt_pc;
    rst        = 1'b1;
    loaded     = 1'b0;
    store_idx  = 0;
    lfsr_state = 32'h6f7d_d556;
    fill_memory();
    load_testdata();
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    while (halt !== 1'b1) begin
      @(negedge clk);
    end
    halt_pc = pc;
    @(posedge clk);
    #1;
    check_value("halt pc hold", halt_pc, pc);
    check_value("halt level", 32'd1, {31'b0, halt});
    check_value("store count", num_stores, store_idx);
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== verif/rv_testdata.hex ====
// header: program words, expected stores, data word index, data word count
// then program words, data words, and store records (address, byte enable, masked data)
00000062 00000023 000000c0 00000002
// arithmetic and logic, register forms
123450B7 67808093 FFD00113 40000513
002081B3 00352023 40208233 00452223
001122B3 00113333 00552423 00652623
0020C3B3 0020E433 0020F4B3 00752823
00852A23 00952C23 00400613 00C116B3
00C15733 40C157B3 00D52E23 02E52023
// immediate forms
02F52223 00809693 01C15713 40115793
02D52423 02E52623 02F52823 0F00F393
F000E413 FFF0C493 FFE0A293 FFE0B313
02752A23 02852C23 02952E23 04552023
// byte and halfword stores
04652223 08150023 081500A3 08150123
081501A3 08151223 08151323 30000593
// loads with extension
00058283 0015C303 00259383 0005D403
0045A483 00358683 08552423 08652623
08752823 08852A23 08952C23 08D52E23
// branches, jal, jalr
00000713 00C60463 10070713 00208463
00170713 00209463 10070713 00C61463
00270713 00114463 10070713 0020C463
00470713 0020D463 10070713 00115463
00870713 0020E463 10070713 00116463
01070713 00117463 10070713 0020F463
02070713 008007EF 10070713 168006E7
// markers, x0, auipc, ecall
10070713 10070713 0AE52023 0AF52223
0AD52423 00500013 0A052623 00001297
0A552823 00000073
// data words at 0x300
C3B2A1F0 7F6E5D4C
// expected stores
00000400 0000000F 12345675
00000404 0000000F 1234567B
00000408 0000000F 00000001
0000040C 0000000F 00000000
00000410 0000000F EDCBA985
00000414 0000000F FFFFFFFD
00000418 0000000F 12345678
0000041C 0000000F FFFFFFD0
00000420 0000000F 0FFFFFFF
00000424 0000000F FFFFFFFF
00000428 0000000F 34567800
0000042C 0000000F 0000000F
00000430 0000000F FFFFFFFE
00000434 0000000F 00000070
00000438 0000000F FFFFFF78
0000043C 0000000F EDCBA987
00000440 0000000F 00000000
00000444 0000000F 00000001
00000480 00000001 00000078
00000480 00000002 00007800
00000480 00000004 00780000
00000480 00000008 78000000
00000484 00000003 00005678
00000484 0000000C 56780000
00000488 0000000F FFFFFFF0
0000048C 0000000F 000000A1
00000490 0000000F FFFFC3B2
00000494 0000000F 0000A1F0
00000498 0000000F 7F6E5D4C
0000049C 0000000F FFFFFFC3
000004A0 0000000F 0000003F
000004A4 0000000F 00000158
000004A8 0000000F 00000160
000004AC 0000000F 00000000
000004B0 0000000F 0000117C

// ==== vlog.f ====
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_lsu.sv
logic/rv_core.sv
verif/tb_rv_core.sv
